/* compile.f */
logic/vmem_pkg.sv
logic/cycle_state_gen.sv
logic/vmem_map.sv
logic/vmem_control.sv
logic/mem_bus_port.sv
logic/vmem_top.sv
sim/vmem_tb.sv

/* logic/cycle_state_gen.sv */
// Processor cycle-state sequencer.
// Steps alu, write, fetch and prefetch, holding in fetch on waiting.

`timescale 1ns/10ps

module cycle_state_gen (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   waiting,
   output vmem_pkg::cycle_state_t state
);

   vmem_pkg::cycle_state_t state_next;

   ////////////////////////////////////////////////////////////////////////////
   // Next state.
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         vmem_pkg::st_alu: begin
            state_next = vmem_pkg::st_write;
         end
         vmem_pkg::st_write: begin
            state_next = vmem_pkg::st_fetch;
         end
         vmem_pkg::st_fetch: begin
            // Processor stalls here until memory catches up.
            if (!waiting) begin
               state_next = vmem_pkg::st_prefetch;
            end
         end
         vmem_pkg::st_prefetch: begin
            state_next = vmem_pkg::st_alu;
         end
         default: begin
            state_next = vmem_pkg::st_alu;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // State register.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= vmem_pkg::st_alu;
      end else begin
         state <= state_next;
      end
   end

endmodule

/* logic/mem_bus_port.sv */
// Memory bus port.
// Latches an accepted operation, drives the bus while requested
// and flags denied accesses.

`timescale 1ns/10ps

module mem_bus_port #(
   parameter int vma_width  = 16,
   parameter int data_width = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   input  vmem_pkg::mem_op_t      op,
   input  logic [vma_width-1:0]   vma,
   input  logic [data_width-1:0]  wdata,
   input  logic                   memcheck,
   input  logic                   memrq,
   input  vmem_pkg::page_perm_t   perm,
   output vmem_pkg::bus_req_t     bus,
   output logic                   fault
);

   vmem_pkg::bus_req_t bus_q;
   logic               denied;

   ////////////////////////////////////////////////////////////////////////////
   // Operation capture.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (op != vmem_pkg::op_none) begin
         bus_q.addr  <= vma;
         bus_q.wdata <= wdata;
         bus_q.write <= (op == vmem_pkg::op_write);
      end
   end

   // Bus is quiet unless a request is up.
   assign bus = memrq ? bus_q : '0;

   ////////////////////////////////////////////////////////////////////////////
   // Fault.
   ////////////////////////////////////////////////////////////////////////////

   // Writes also need write_ok.
   assign denied = !perm.access || (bus_q.write && !perm.write_ok);

   always_ff @(posedge clk) begin
      if (reset) begin
         fault <= 1'b0;
      end else begin
         fault <= memcheck && denied;
      end
   end

endmodule

/* logic/vmem_control.sv */
// Memory control block.
// Prepare, start and check steps, page permission terms, read and
// write cycle flags, bus request and processor wait.

`timescale 1ns/10ps

module vmem_control (
   input  logic                   clk,
   input  logic                   reset,
   input  vmem_pkg::cycle_state_t state,
   input  vmem_pkg::mem_op_t      op,
   input  logic                   lcinc,
   input  logic                   needfetch,
   input  logic                   memack,
   input  vmem_pkg::page_perm_t   perm,
   output logic                   memprepare,
   output logic                   memstart,
   output logic                   memcheck,
   output logic                   memrq,
   output logic                   vmaok,
   output logic                   wrcyc,
   output logic                   waiting
);

   logic state_alu;
   logic state_write;
   logic state_fetch;
   logic state_prefetch;

   logic              memop;
   logic              memwr;
   vmem_pkg::mem_op_t op_q;
   logic              rdcyc;
   logic              mbusy;
   logic              mfinish;
   logic              pfr;
   logic              pfw;

   ////////////////////////////////////////////////////////////////////////////
   // State strobes and operation decode.
   ////////////////////////////////////////////////////////////////////////////

   assign state_alu      = (state == vmem_pkg::st_alu);
   assign state_write    = (state == vmem_pkg::st_write);
   assign state_fetch    = (state == vmem_pkg::st_fetch);
   assign state_prefetch = (state == vmem_pkg::st_prefetch);

   assign memop = (op != vmem_pkg::op_none);

   // Held from the strobe for the direction decision later on.
   always_ff @(posedge clk) begin
      if (reset) begin
         op_q <= vmem_pkg::op_none;
      end else if (memop) begin
         op_q <= op;
      end
   end

   assign memwr = (op_q == vmem_pkg::op_write);

   ////////////////////////////////////////////////////////////////////////////
   // Prepare, start, check.
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         memprepare <= 1'b0;
         memstart   <= 1'b0;
         memcheck   <= 1'b0;
      end else begin
         memprepare <= (state_alu || state_write) && memop;
         // Map read starts once the alu cycle is over.
         memstart   <= !state_alu && memprepare;
         memcheck   <= memstart;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Permissions and cycle flags.
   ////////////////////////////////////////////////////////////////////////////

   assign pfw = perm.access & perm.write_ok & wrcyc;
   assign pfr = perm.access & rdcyc;

   always_ff @(posedge clk) begin
      if (reset) begin
         vmaok <= 1'b0;
      end else if (memcheck) begin
         vmaok <= pfr | pfw;
      end
   end

   // Direction is fixed in fetch or prefetch, ahead of the check cycle.
   always_ff @(posedge clk) begin
      if (reset) begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end else if ((state_fetch || state_prefetch) && memstart && !memcheck) begin
         rdcyc <= !memwr;
         wrcyc <= memwr;
      end else if ((!memrq && !memprepare && !memstart) || mfinish) begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus request and wait.
   ////////////////////////////////////////////////////////////////////////////

   assign mfinish = memack | reset;

   always_ff @(posedge clk) begin
      if (mfinish) begin
         mbusy <= 1'b0;
      end else if (memcheck && (pfr || pfw)) begin
         mbusy <= 1'b1;
      end
   end

   assign memrq   = mbusy | (memcheck & ~memstart & (pfr | pfw));
   assign waiting = (memrq & mbusy) | (lcinc & needfetch & mbusy);

endmodule

/* logic/vmem_map.sv */
// Loadable page map.
// One permission entry per page, read by the upper address bits.

`timescale 1ns/10ps

module vmem_map #(
   parameter int vma_width = 16,
   parameter int page_bits = 4
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [vma_width-1:0]  vma,
   input  logic                  load_en,
   input  vmem_pkg::map_load_t   load,
   output vmem_pkg::page_perm_t  perm
);

   localparam int num_pages = 2 ** page_bits;

   ////////////////////////////////////////////////////////////////////////////
   // Permission table.
   ////////////////////////////////////////////////////////////////////////////

   vmem_pkg::page_perm_t map_q [num_pages];

   logic [page_bits-1:0] page_idx;

   // Page index is the top of the virtual address.
   assign page_idx = vma[vma_width-1 -: page_bits];

   // Every page starts out with no access.
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_pages; i++) begin
            map_q[i] <= '0;
         end
      end else if (load_en) begin
         map_q[load.page] <= load.perm;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Lookup.
   ////////////////////////////////////////////////////////////////////////////

   // Combinational read, so the bits are ready in the check cycle.
   assign perm = map_q[page_idx];

endmodule

/* logic/vmem_pkg.sv */
// Shared types for the virtual-memory control slice.
// Memory operation and cycle-state enums, page permission,
// page map update and bus request structs.

package vmem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Default widths, matched by the top-level parameters.
   ////////////////////////////////////////////////////////////////////////////

   localparam int vma_width  = 16;
   localparam int page_bits  = 4;
   localparam int data_width = 16;

   ////////////////////////////////////////////////////////////////////////////
   // Enums.
   ////////////////////////////////////////////////////////////////////////////

   // Memory operation requested by the processor.
   typedef enum logic [1:0] {
      op_none   = 2'd0,
      op_read   = 2'd1,
      op_write  = 2'd2,
      op_ifetch = 2'd3
   } mem_op_t;

   // Processor cycle state.
   typedef enum logic [1:0] {
      st_alu      = 2'd0,
      st_write    = 2'd1,
      st_fetch    = 2'd2,
      st_prefetch = 2'd3
   } cycle_state_t;

   ////////////////////////////////////////////////////////////////////////////
   // Structs.
   ////////////////////////////////////////////////////////////////////////////

   // Page access bits, access is valid and readable.
   typedef struct packed {
      logic access;
      logic write_ok;
   } page_perm_t;

   // Bus cycle presented to memory.
   typedef struct packed {
      logic [vma_width-1:0]  addr;
      logic [data_width-1:0] wdata;
      logic                  write;
   } bus_req_t;

   // One page map update.
   typedef struct packed {
      logic [page_bits-1:0] page;
      page_perm_t           perm;
   } map_load_t;

endpackage

/* logic/vmem_top.sv */
// Top level of the virtual-memory control slice.
// Sequencer, page map, memory control and bus port.

`timescale 1ns/10ps

module vmem_top #(
   parameter int vma_width  = 16,
   parameter int page_bits  = 4,
   parameter int data_width = 16
) (
   input  logic                   clk,
   input  logic                   reset,
   input  vmem_pkg::mem_op_t      op,
   input  logic [vma_width-1:0]   vma,
   input  logic [data_width-1:0]  wdata,
   input  logic                   lcinc,
   input  logic                   needfetch,
   input  logic                   memack,
   input  logic                   map_load_en,
   input  vmem_pkg::map_load_t    map_load,
   output vmem_pkg::bus_req_t     bus,
   output logic                   memrq,
   output logic                   waiting,
   output logic                   fault,
   output vmem_pkg::cycle_state_t state
);

   vmem_pkg::page_perm_t perm;
   logic                 memcheck;

   cycle_state_gen i_state (
      .clk     (clk),
      .reset   (reset),
      .waiting (waiting),
      .state   (state)
   );

   // Lookup follows vma, so vma stays put until the check cycle.
   vmem_map #(
      .vma_width (vma_width),
      .page_bits (page_bits)
   ) i_map (
      .clk     (clk),
      .reset   (reset),
      .vma     (vma),
      .load_en (map_load_en),
      .load    (map_load),
      .perm    (perm)
   );

   // Pipeline steps and vmaok stay internal to the control.
   vmem_control i_control (
      .clk        (clk),
      .reset      (reset),
      .state      (state),
      .op         (op),
      .lcinc      (lcinc),
      .needfetch  (needfetch),
      .memack     (memack),
      .perm       (perm),
      .memprepare (),
      .memstart   (),
      .memcheck   (memcheck),
      .memrq      (memrq),
      .vmaok      (),
      .wrcyc      (),
      .waiting    (waiting)
   );

   mem_bus_port #(
      .vma_width  (vma_width),
      .data_width (data_width)
   ) i_bus_port (
      .clk      (clk),
      .reset    (reset),
      .op       (op),
      .vma      (vma),
      .wdata    (wdata),
      .memcheck (memcheck),
      .memrq    (memrq),
      .perm     (perm),
      .bus      (bus),
      .fault    (fault)
   );

endmodule

/* sim/vmem_golden.txt */
# m <page> <access write_ok>
# o <vma> <op 1 rd 2 wr 3 if> <wdata> <delay -1=rand> <b|f> <bus addr> <bus wdata> <bus write>
o 1234 1 5a5a 2 f 0000 0000 0
m 1 10
o 1234 1 5a5a 2 b 1234 5a5a 0
o 1abc 2 c0de 3 f 0000 0000 0
m 1 11
o 1abc 2 c0de 0 b 1abc c0de 1
o 1ff0 3 0f0f -1 b 1ff0 0f0f 0
m 7 11
o 7000 2 1111 -1 b 7000 1111 1
o 7002 1 2222 5 b 7002 2222 0
m 7 00
o 7004 1 3333 1 f 0000 0000 0
o 7006 2 4444 1 f 0000 0000 0
m 7 10
o 7008 1 5555 -1 b 7008 5555 0
o 7008 2 6666 2 f 0000 0000 0
o f00e 3 7777 0 f 0000 0000 0
m f 11
o fffe 2 8888 -1 b fffe 8888 1
o 1000 1 9999 1 b 1000 9999 0
o 2000 2 aaaa 0 f 0000 0000 0

/* sim/vmem_tb.sv */
// Testbench for the virtual-memory control slice.
// Clock, reset, golden-file reader, bus responder and compare tasks.

`timescale 1ns/10ps

module vmem_tb;

   localparam int slot_timeout = 16;
   localparam int rq_timeout   = 16;
   localparam int drop_timeout = 8;

   logic                            clk;
   logic                            reset;
   vmem_pkg::mem_op_t               op;
   logic [vmem_pkg::vma_width-1:0]  vma;
   logic [vmem_pkg::data_width-1:0] wdata;
   logic                            lcinc;
   logic                            needfetch;
   logic                            memack;
   logic                            map_load_en;
   vmem_pkg::map_load_t             map_load;
   vmem_pkg::bus_req_t              bus;
   logic                            memrq;
   logic                            waiting;
   logic                            fault;
   vmem_pkg::cycle_state_t          state;

   integer seed;
   int     op_count;
   int     load_count;

   vmem_top i_dut (
      .clk         (clk),
      .reset       (reset),
      .op          (op),
      .vma         (vma),
      .wdata       (wdata),
      .lcinc       (lcinc),
      .needfetch   (needfetch),
      .memack      (memack),
      .map_load_en (map_load_en),
      .map_load    (map_load),
      .bus         (bus),
      .memrq       (memrq),
      .waiting     (waiting),
      .fault       (fault),
      .state       (state)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks.
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort_run;
      $display("sim failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_bus(input string name, input vmem_pkg::bus_req_t got,
                            input vmem_pkg::bus_req_t exp);
      if (got !== exp) begin
         $display("Error: %s got addr %h wdata %h write %h, expected addr %h wdata %h write %h",
                  name, got.addr, got.wdata, got.write, exp.addr, exp.wdata, exp.write);
         abort_run();
      end
   endtask

   task automatic check_fault(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: fault got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_state(input string name, input vmem_pkg::cycle_state_t got,
                              input vmem_pkg::cycle_state_t exp);
      if (got !== exp) begin
         $display("Error: %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("Error: %s got %0h expected %0h", name, got, exp);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and bus responder.
   ////////////////////////////////////////////////////////////////////////////

   // Sequencer position a given number of cycles into a bus cycle.
   // Alu comes first and fetch holds while the processor waits.
   function automatic vmem_pkg::cycle_state_t busy_state(input int busy_cycle);
      if (busy_cycle == 0) begin
         return vmem_pkg::st_alu;
      end else if (busy_cycle == 1) begin
         return vmem_pkg::st_write;
      end
      return vmem_pkg::st_fetch;
   endfunction

   // Op must be seen in alu, which always follows prefetch.
   task automatic wait_for_alu_slot;
      int cycles;
      cycles = 0;
      while (1) begin
         @(negedge clk);
         if (state == vmem_pkg::st_prefetch) break;
         cycles++;
         if (cycles >= slot_timeout) begin
            $display("Timeout: the sequencer never reached prefetch between operations");
            abort_run();
         end
      end
      // Idle bus between operations.
      check_level("memrq", memrq, 1'b0);
      check_level("waiting", waiting, 1'b0);
      check_fault(fault, 1'b0);
      check_bus("bus", bus, '0);
   endtask

   task automatic load_page(input logic [vmem_pkg::page_bits-1:0] page,
                            input vmem_pkg::page_perm_t perm);
      @(posedge clk);
      map_load_en <= 1'b1;
      map_load    <= {page, perm};
      @(posedge clk);
      map_load_en <= 1'b0;
      load_count++;
   endtask

   task automatic strobe_op(input logic [vmem_pkg::vma_width-1:0] addr,
                            input vmem_pkg::mem_op_t op_v,
                            input logic [vmem_pkg::data_width-1:0] data);
      integer fetch_bits;
      fetch_bits = $random(seed);
      wait_for_alu_slot();
      @(posedge clk);
      op        <= op_v;
      vma       <= addr;
      wdata     <= data;
      lcinc     <= fetch_bits[0];
      needfetch <= fetch_bits[1];
      // vma stays put because the map is read again in the check cycle.
      @(posedge clk);
      op <= vmem_pkg::op_none;
   endtask

   task automatic wait_for_outcome(output int cycles);
      cycles = 0;
      while (1) begin
         @(negedge clk);
         cycles++;
         if (memrq || fault) break;
         if (cycles >= rq_timeout) begin
            $display("Timeout: neither memrq nor fault came after the op strobe");
            abort_run();
         end
      end
   endtask

   task automatic wait_for_drop;
      int cycles;
      cycles = 0;
      while (1) begin
         @(negedge clk);
         cycles++;
         if (!memrq) break;
         if (cycles >= drop_timeout) begin
            $display("Timeout: memrq stayed high after memack");
            abort_run();
         end
      end
      check_count("memrq drop cycles", cycles, 1);
      check_level("waiting", waiting, 1'b0);
      check_bus("bus", bus, '0);
   endtask

   // Memory side holds memack off for the delay and then pulses it.
   task automatic answer_bus(input int delay, input vmem_pkg::bus_req_t exp_bus);
      for (int i = 0; i < delay; i++) begin
         @(negedge clk);
         check_level("memrq", memrq, 1'b1);
         check_level("waiting", waiting, 1'b1);
         check_bus("bus", bus, exp_bus);
         check_state("state", state, busy_state(i));
      end
      @(posedge clk);
      memack <= 1'b1;
      @(negedge clk);
      check_level("memrq", memrq, 1'b1);
      check_level("waiting", waiting, 1'b1);
      check_state("state", state, busy_state(delay));
      @(posedge clk);
      memack <= 1'b0;
      wait_for_drop();
      check_state("state", state, busy_state(delay + 1));
   endtask

   task automatic run_operation(input logic [vmem_pkg::vma_width-1:0] addr,
                                input vmem_pkg::mem_op_t op_v,
                                input logic [vmem_pkg::data_width-1:0] data,
                                input int delay_field, input logic expect_fault,
                                input vmem_pkg::bus_req_t exp_bus);
      int delay;
      int cycles;
      if (delay_field < 0) begin
         delay = $unsigned($random(seed)) % 6;
      end else begin
         delay = delay_field;
      end
      strobe_op(addr, op_v, data);
      wait_for_outcome(cycles);
      check_fault(fault, expect_fault);
      if (expect_fault) begin
         // Fault comes one cycle after the check cycle.
         check_count("fault latency", cycles, 4);
         check_level("memrq", memrq, 1'b0);
         check_level("waiting", waiting, 1'b0);
         check_state("state", state, vmem_pkg::st_alu);
         @(negedge clk);
         check_fault(fault, 1'b0);
         check_level("memrq", memrq, 1'b0);
      end else begin
         check_count("memrq latency", cycles, 3);
         check_bus("bus", bus, exp_bus);
         check_state("state", state, vmem_pkg::st_prefetch);
         answer_bus(delay, exp_bus);
      end
      op_count++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      integer                          fd;
      integer                          code;
      logic [7:0]                      kind;
      logic [8*160-1:0]                skip_line;
      logic [vmem_pkg::page_bits-1:0]  page_v;
      logic [1:0]                      perm_v;
      logic [vmem_pkg::vma_width-1:0]  addr_v;
      integer                          op_code;
      logic [vmem_pkg::data_width-1:0] data_v;
      integer                          delay_v;
      logic [7:0]                      result;
      logic [vmem_pkg::vma_width-1:0]  exp_addr;
      logic [vmem_pkg::data_width-1:0] exp_wdata;
      logic                            exp_write;

      seed        = 32'h77cdea89;
      op_count    = 0;
      load_count  = 0;
      reset       <= 1'b1;
      op          <= vmem_pkg::op_none;
      vma         <= '0;
      wdata       <= '0;
      lcinc       <= 1'b0;
      needfetch   <= 1'b0;
      memack      <= 1'b0;
      map_load_en <= 1'b0;
      map_load    <= '0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;

      // Quiet outputs and the alu state straight out of reset.
      @(negedge clk);
      check_state("state", state, vmem_pkg::st_alu);
      check_level("memrq", memrq, 1'b0);
      check_level("waiting", waiting, 1'b0);
      check_fault(fault, 1'b0);

      fd = $fopen("sim/vmem_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden file sim/vmem_golden.txt");
         abort_run();
      end

      while (1) begin
         code = $fscanf(fd, " %c", kind);
         if (code != 1) break;
         if (kind == "#") begin
            code = $fgets(skip_line, fd);
         end else if (kind == "m") begin
            code = $fscanf(fd, "%h %b", page_v, perm_v);
            if (code != 2) begin
               $display("Malformed map load line in the golden file");
               abort_run();
            end
            load_page(page_v, perm_v);
         end else if (kind == "o") begin
            code = $fscanf(fd, "%h %d %h %d %c %h %h %b", addr_v, op_code, data_v,
                           delay_v, result, exp_addr, exp_wdata, exp_write);
            if (code != 8) begin
               $display("Malformed operation line in the golden file");
               abort_run();
            end
            run_operation(addr_v, vmem_pkg::mem_op_t'(op_code[1:0]), data_v, delay_v,
                          (result == "f"), {exp_addr, exp_wdata, exp_write});
         end else begin
            $display("Unknown line kind %c in the golden file", kind);
            abort_run();
         end
      end
      $fclose(fd);

      repeat (4) @(posedge clk);
      $display("Ran %0d operations and %0d map loads", op_count, load_count);
      if (op_count > 0) begin
         $display("sim passed");
      end else begin
         $display("No operations were read from the golden file");
         abort_run();
      end
      $finish;
   end

endmodule
